// ==== common/ts_pkg.sv ====
`default_nettype none

package ts_pkg;

    // dram geometry, word addressed
    localparam int RAM_AW = 12;
    localparam int RAM_DW = 16;

    // fclk cycles per dram slot, c0..c3
    localparam int SLOT_PHASES = 4;

    // words per video line
    localparam int VIDEO_LINE_WORDS = 8;

    localparam int DMA_LEN_W = 8;

    typedef logic [RAM_AW-1:0] dram_addr_t;
    typedef logic [RAM_DW-1:0] dram_data_t;

    // one dram access
    // bsel[0] is the low byte, bsel[1] the high byte
    typedef struct packed {
        dram_addr_t addr;
        dram_data_t wdata;
        logic       rnw;
        logic [1:0] bsel;
    } dram_req_t;

    // len counts words, zero means nothing to copy
    typedef struct packed {
        dram_addr_t           src;
        dram_addr_t           dst;
        logic [DMA_LEN_W-1:0] len;
    } dma_cfg_t;

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_VIDEO,
        OWNER_CPU,
        OWNER_DMA
    } slot_owner_e;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_READ,
        DMA_WRITE
    } dma_state_e;

endpackage

`default_nettype wire

// ==== arbiter/dram_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module dram_arbiter (
    input  wire                fclk,
    input  wire                reset,
    input  wire                video_req,
    input  wire                cpu_req,
    input  wire                dma_req,
    input  ts_pkg::dram_req_t  video_rq,
    input  ts_pkg::dram_req_t  cpu_rq,
    input  ts_pkg::dram_req_t  dma_rq,
    output logic               video_next,
    output logic               cpu_next,
    output logic               dma_next,
    output ts_pkg::dram_req_t  slot_rq,
    output logic               slot_go
);

    import ts_pkg::*;

    logic [$clog2(SLOT_PHASES)-1:0] phase;
    logic                           last;
    slot_owner_e                    slot_owner;
    slot_owner_e                    pick;
    logic                           video_ok;
    logic                           cpu_ok;
    logic                           dma_ok;

    // c3 of the slot
    assign last = (phase == $bits(phase)'(SLOT_PHASES - 1));

    always_ff @(posedge fclk) begin
        if (reset) begin
            phase <= '0;
        end else if (last) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // the current owner still holds req while its next is out,
    // so it cannot win the following slot
    assign video_ok = video_req && (slot_owner != OWNER_VIDEO);
    assign cpu_ok   = cpu_req && (slot_owner != OWNER_CPU);
    assign dma_ok   = dma_req && (slot_owner != OWNER_DMA);

    // fixed priority: video, cpu, dma
    always_comb begin
        if (video_ok) begin
            pick = OWNER_VIDEO;
        end else if (cpu_ok) begin
            pick = OWNER_CPU;
        end else if (dma_ok) begin
            pick = OWNER_DMA;
        end else begin
            pick = OWNER_NONE;
        end
    end

    always_ff @(posedge fclk) begin
        if (reset) begin
            slot_owner <= OWNER_NONE;
        end else if (last) begin
            slot_owner <= pick;
        end
    end

    always_ff @(posedge fclk) begin
        if (last) begin
            case (pick)
                OWNER_VIDEO: slot_rq <= video_rq;
                OWNER_CPU:   slot_rq <= cpu_rq;
                OWNER_DMA:   slot_rq <= dma_rq;
                default:     slot_rq <= slot_rq;
            endcase
        end
    end

    assign slot_go = (phase == '0) && (slot_owner != OWNER_NONE);

    // rdata is already registered by c3
    assign video_next = last && (slot_owner == OWNER_VIDEO);
    assign cpu_next   = last && (slot_owner == OWNER_CPU);
    assign dma_next   = last && (slot_owner == OWNER_DMA);

endmodule

`default_nettype wire

// ==== dram/dram_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dram_ctrl (
    input  wire                 fclk,
    input  wire                 slot_go,
    input  ts_pkg::dram_req_t   slot_rq,
    output ts_pkg::dram_data_t  dram_rdata
);

    import ts_pkg::*;

    dram_data_t mem [0:2**RAM_AW-1];

    // one access per owned slot, done in c0
    always_ff @(posedge fclk) begin
        if (slot_go && !slot_rq.rnw) begin
            if (slot_rq.bsel[0]) begin
                mem[slot_rq.addr][7:0] <= slot_rq.wdata[7:0];
            end
            if (slot_rq.bsel[1]) begin
                mem[slot_rq.addr][RAM_DW-1:8] <= slot_rq.wdata[RAM_DW-1:8];
            end
        end
    end

    // read word held until the next read slot
    always_ff @(posedge fclk) begin
        if (slot_go && slot_rq.rnw) begin
            dram_rdata <= mem[slot_rq.addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/video_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_fetch (
    input  wire                 fclk,
    input  wire                 reset,
    input  wire                 line_start,
    input  ts_pkg::dram_addr_t  base,
    input  wire                 next,
    input  ts_pkg::dram_data_t  rdata,
    output logic                req,
    output ts_pkg::dram_req_t   rq,
    output ts_pkg::dram_data_t  pix_word,
    output logic                pix_valid
);

    import ts_pkg::*;

    dram_addr_t                                 addr;
    logic [$clog2(VIDEO_LINE_WORDS + 1)-1:0]    cnt;

    // restart wins over a pending next
    always_ff @(posedge fclk) begin
        if (reset) begin
            cnt <= '0;
        end else if (line_start) begin
            cnt <= $bits(cnt)'(VIDEO_LINE_WORDS);
        end else if (next && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge fclk) begin
        if (line_start) begin
            addr <= base;
        end else if (next) begin
            addr <= addr + 1'b1;
        end
    end

    assign req = (cnt != '0);
    assign rq  = '{addr: addr, wdata: '0, rnw: 1'b1, bsel: 2'b11};

    always_ff @(posedge fclk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= next;
        end
    end

    // pixel word
    always_ff @(posedge fclk) begin
        if (next) begin
            pix_word <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_copy.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_copy (
    input  wire                 fclk,
    input  wire                 reset,
    input  wire                 start,
    input  ts_pkg::dma_cfg_t    cfg,
    input  wire                 next,
    input  ts_pkg::dram_data_t  rdata,
    output logic                req,
    output ts_pkg::dram_req_t   rq,
    output logic                act
);

    import ts_pkg::*;

    dma_state_e           state;
    dram_addr_t           src;
    dram_addr_t           dst;
    logic [DMA_LEN_W-1:0] len;
    dram_data_t           data;

    assign act = (state != DMA_IDLE);
    assign req = act;

    always_ff @(posedge fclk) begin
        if (reset) begin
            state <= DMA_IDLE;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (start && cfg.len != '0) begin
                        state <= DMA_READ;
                    end
                end
                DMA_READ: begin
                    if (next) begin
                        state <= DMA_WRITE;
                    end
                end
                DMA_WRITE: begin
                    // last word written
                    if (next) begin
                        state <= (len == 1) ? DMA_IDLE : DMA_READ;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (state == DMA_IDLE && start) begin
            src <= cfg.src;
            dst <= cfg.dst;
            len <= cfg.len;
        end else if (state == DMA_WRITE && next) begin
            src <= src + 1'b1;
            dst <= dst + 1'b1;
            len <= len - 1'b1;
        end
    end

    // word in transit
    always_ff @(posedge fclk) begin
        if (state == DMA_READ && next) begin
            data <= rdata;
        end
    end

    always_comb begin
        if (state == DMA_WRITE) begin
            rq = '{addr: dst, wdata: data, rnw: 1'b0, bsel: 2'b11};
        end else begin
            rq = '{addr: src, wdata: data, rnw: 1'b1, bsel: 2'b11};
        end
    end

endmodule

`default_nettype wire

// ==== design/ts_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_top (
    input  wire                  fclk,
    input  wire                  reset,
    input  wire                  cpu_req,
    input  ts_pkg::dram_req_t    cpu_rq,
    input  wire                  video_line_start,
    input  ts_pkg::dram_addr_t   video_base,
    input  wire                  dma_start,
    input  ts_pkg::dma_cfg_t     dma_cfg,
    output logic                 cpu_next,
    output ts_pkg::dram_data_t   cpu_rdata,
    output ts_pkg::dram_data_t   pix_word,
    output logic                 pix_valid,
    output logic                 dma_act
);

    import ts_pkg::*;

    logic       video_req;
    logic       video_next;
    dram_req_t  video_rq;

    logic       dma_req;
    logic       dma_next;
    dram_req_t  dma_rq;

    dram_req_t  slot_rq;
    logic       slot_go;
    dram_data_t dram_rdata;

    // read data is shared by all clients
    assign cpu_rdata = dram_rdata;

    dram_arbiter dram_arbiter
    (
        .fclk(fclk),
        .reset(reset),
        .video_req(video_req),
        .cpu_req(cpu_req),
        .dma_req(dma_req),
        .video_rq(video_rq),
        .cpu_rq(cpu_rq),
        .dma_rq(dma_rq),
        .video_next(video_next),
        .cpu_next(cpu_next),
        .dma_next(dma_next),
        .slot_rq(slot_rq),
        .slot_go(slot_go)
    );

    dram_ctrl dram_ctrl
    (
        .fclk(fclk),
        .slot_go(slot_go),
        .slot_rq(slot_rq),
        .dram_rdata(dram_rdata)
    );

    video_fetch video_fetch
    (
        .fclk(fclk),
        .reset(reset),
        .line_start(video_line_start),
        .base(video_base),
        .next(video_next),
        .rdata(dram_rdata),
        .req(video_req),
        .rq(video_rq),
        .pix_word(pix_word),
        .pix_valid(pix_valid)
    );

    dma_copy dma_copy
    (
        .fclk(fclk),
        .reset(reset),
        .start(dma_start),
        .cfg(dma_cfg),
        .next(dma_next),
        .rdata(dram_rdata),
        .req(dma_req),
        .rq(dma_rq),
        .act(dma_act)
    );

endmodule

`default_nettype wire

// ==== tb/ts_top_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dram_arbiter_checker (
    input wire fclk,
    input wire reset,
    input wire video_next,
    input wire cpu_next,
    input wire dma_next,
    input wire slot_go
);

    import ts_pkg::*;

    logic                           any_next;
    logic [$clog2(SLOT_PHASES)-1:0] slot_phase;

    assign any_next = video_next || cpu_next || dma_next;

    // slot phase counted from reset, apart from the arbiter's own counter
    always_ff @(posedge fclk) begin
        if (reset) begin
            slot_phase <= '0;
        end else if (slot_phase == $bits(slot_phase)'(SLOT_PHASES - 1)) begin
            slot_phase <= '0;
        end else begin
            slot_phase <= slot_phase + 1'b1;
        end
    end

    one_next: assert property (@(posedge fclk) disable iff (reset)
        $onehot0({video_next, cpu_next, dma_next}))
        else $error("more than one next pulse in a cycle");

    // next is a single-cycle pulse
    next_pulse: assert property (@(posedge fclk) disable iff (reset) any_next |=> !any_next)
        else $error("next held for more than one cycle");

    go_in_c0: assert property (@(posedge fclk) disable iff (reset) slot_go |-> slot_phase == '0)
        else $error("slot_go outside phase 0");

endmodule

bind dram_arbiter dram_arbiter_checker arbiter_checker (
    .fclk(fclk),
    .reset(reset),
    .video_next(video_next),
    .cpu_next(cpu_next),
    .dma_next(dma_next),
    .slot_go(slot_go)
);

`default_nettype wire

// ==== tb/ts_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_top_tb;

    import ts_pkg::*;

    // five tests of about 100 slots each, doubled
    localparam int CYCLE_LIMIT = 2 * 5 * 100 * SLOT_PHASES;

    logic       fclk;
    logic       reset;
    logic       cpu_req;
    dram_req_t  cpu_rq;
    logic       video_line_start;
    dram_addr_t video_base;
    logic       dma_start;
    dma_cfg_t   dma_cfg;
    logic       cpu_next;
    dram_data_t cpu_rdata;
    dram_data_t pix_word;
    logic       pix_valid;
    logic       dma_act;

    integer     seed;
    int         word_errors;
    int         flag_errors;
    int         cycles;
    dram_data_t shadow [0:2**RAM_AW-1];
    dram_data_t pix_q [$];

    ts_top uut (
        .fclk(fclk),
        .reset(reset),
        .cpu_req(cpu_req),
        .cpu_rq(cpu_rq),
        .video_line_start(video_line_start),
        .video_base(video_base),
        .dma_start(dma_start),
        .dma_cfg(dma_cfg),
        .cpu_next(cpu_next),
        .cpu_rdata(cpu_rdata),
        .pix_word(pix_word),
        .pix_valid(pix_valid),
        .dma_act(dma_act)
    );

    initial begin
        fclk = 1'b0;
        forever #50 fclk = ~fclk;
    end

    // pixel words as they leave the fetcher
    always @(negedge fclk) begin
        if (pix_valid === 1'b1) begin
            pix_q.push_back(pix_word);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge fclk);
            cycles = cycles + 1;
        end
        $display("ERROR: run exceeded its cycle limit of %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_word(input dram_data_t got, input dram_data_t exp, input string msg);
        if (got !== exp) begin
            word_errors = word_errors + 1;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            flag_errors = flag_errors + 1;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // expected word after a write with byte select
    function automatic dram_data_t merge_bytes(input dram_data_t old_w, input dram_data_t new_w,
                                               input logic [1:0] bsel);
        dram_data_t w;
        w = old_w;
        if (bsel[0]) w[7:0] = new_w[7:0];
        if (bsel[1]) w[15:8] = new_w[15:8];
        return w;
    endfunction

    // holds req until cpu_next, drops it on the following edge
    task automatic cpu_access(input dram_addr_t addr, input dram_data_t wdata, input logic rnw,
                              input logic [1:0] bsel, output dram_data_t rdata);
        dram_req_t rq;
        rq.addr  = addr;
        rq.wdata = wdata;
        rq.rnw   = rnw;
        rq.bsel  = bsel;
        @(posedge fclk);
        cpu_req <= 1'b1;
        cpu_rq  <= rq;
        @(negedge fclk);
        while (cpu_next !== 1'b1) @(negedge fclk);
        rdata = cpu_rdata;
        @(posedge fclk);
        cpu_req <= 1'b0;
    endtask

    task automatic cpu_write(input dram_addr_t addr, input dram_data_t wdata,
                             input logic [1:0] bsel);
        dram_data_t unused;
        shadow[addr] = merge_bytes(shadow[addr], wdata, bsel);
        cpu_access(addr, wdata, 1'b0, bsel, unused);
    endtask

    task automatic read_and_check(input dram_addr_t addr, input string msg);
        dram_data_t rd;
        cpu_access(addr, '0, 1'b1, 2'b11, rd);
        check_word(rd, shadow[addr], $sformatf("%s at %h", msg, addr));
    endtask

    task automatic fill_words(input dram_addr_t base, input int count);
        dram_addr_t a;
        dram_data_t w;
        for (int i = 0; i < count; i++) begin
            a = base + i;
            w = $random(seed);
            cpu_write(a, w, 2'b11);
        end
    endtask

    task automatic start_video(input dram_addr_t base);
        @(posedge fclk);
        video_base       <= base;
        video_line_start <= 1'b1;
        @(posedge fclk);
        video_line_start <= 1'b0;
    endtask

    task automatic check_video_line(input dram_addr_t base);
        dram_addr_t a;
        check_flag(pix_q.size() == VIDEO_LINE_WORDS, 1'b1, "pix_valid pulse count per line");
        for (int i = 0; i < pix_q.size() && i < VIDEO_LINE_WORDS; i++) begin
            a = base + i;
            check_word(pix_q[i], shadow[a], $sformatf("pixel word %0d", i));
        end
    endtask

    task automatic run_dma(input dma_cfg_t cfg);
        dram_addr_t s;
        dram_addr_t d;
        @(posedge fclk);
        dma_cfg   <= cfg;
        dma_start <= 1'b1;
        @(posedge fclk);
        dma_start <= 1'b0;
        @(negedge fclk);
        check_flag(dma_act, 1'b1, "dma_act after dma_start");
        while (dma_act !== 1'b0) @(negedge fclk);
        // a completed copy leaves dst equal to src
        for (int i = 0; i < cfg.len; i++) begin
            s = cfg.src + i;
            d = cfg.dst + i;
            shadow[d] = shadow[s];
        end
    endtask

    task automatic write_read_words();
        fill_words(12'h010, 16);
        for (int i = 0; i < 16; i++) begin
            read_and_check(12'h010 + i, "cpu read-back");
        end
    endtask

    task automatic byte_select_writes();
        dram_data_t w;
        w = $random(seed);
        cpu_write(12'h200, w, 2'b11);
        w = $random(seed);
        cpu_write(12'h200, w, 2'b01);
        read_and_check(12'h200, "low byte write");
        w = $random(seed);
        cpu_write(12'h200, w, 2'b10);
        read_and_check(12'h200, "high byte write");
    endtask

    task automatic fetch_video_line();
        fill_words(12'h300, VIDEO_LINE_WORDS);
        pix_q.delete();
        start_video(12'h300);
        while (pix_q.size() < VIDEO_LINE_WORDS) @(negedge fclk);
        // room for a stray extra word
        repeat (3 * SLOT_PHASES) @(negedge fclk);
        check_video_line(12'h300);
    endtask

    task automatic copy_dma_block();
        dma_cfg_t cfg;
        cfg.src = 12'h400;
        cfg.dst = 12'h500;
        cfg.len = 10;
        fill_words(cfg.src, 10);
        run_dma(cfg);
        for (int i = 0; i < 10; i++) begin
            read_and_check(cfg.dst + i, "dma destination");
        end
        for (int i = 0; i < 10; i++) begin
            read_and_check(cfg.src + i, "dma source");
        end
    endtask

    task automatic contend_all_clients();
        dma_cfg_t   cfg;
        dram_data_t cpu_word;
        int         pix_before;
        cfg.src = 12'h700;
        cfg.dst = 12'h780;
        cfg.len = 4;
        fill_words(12'h600, VIDEO_LINE_WORDS);
        fill_words(cfg.src, 4);
        pix_q.delete();
        // all three start on the same edge
        fork
            start_video(12'h600);
            run_dma(cfg);
            begin
                cpu_access(12'h010, '0, 1'b1, 2'b11, cpu_word);
                pix_before = pix_q.size();
            end
        join
        while (pix_q.size() < VIDEO_LINE_WORDS) @(negedge fclk);
        repeat (3 * SLOT_PHASES) @(negedge fclk);
        check_video_line(12'h600);
        check_word(cpu_word, shadow[12'h010], "cpu read under contention");
        check_flag(pix_before <= VIDEO_LINE_WORDS, 1'b1, "cpu wait behind video line");
        for (int i = 0; i < 4; i++) begin
            read_and_check(cfg.dst + i, "dma destination under contention");
        end
    endtask

    initial begin
        seed             = 32'h6fa56d7a;
        word_errors      = 0;
        flag_errors      = 0;
        reset            = 1'b1;
        cpu_req          = 1'b0;
        cpu_rq           = '0;
        video_line_start = 1'b0;
        video_base       = '0;
        dma_start        = 1'b0;
        dma_cfg          = '0;
        repeat (5) @(posedge fclk);
        reset <= 1'b0;
        @(negedge fclk);
        check_flag(cpu_next, 1'b0, "cpu_next after reset");
        check_flag(pix_valid, 1'b0, "pix_valid after reset");
        check_flag(dma_act, 1'b0, "dma_act after reset");
        write_read_words();
        byte_select_writes();
        fetch_video_line();
        copy_dma_block();
        contend_all_clients();
        $display("errors: %0d word mismatches, %0d flag mismatches", word_errors, flag_errors);
        if (word_errors == 0 && flag_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/ts_pkg.sv
arbiter/dram_arbiter.sv
dram/dram_ctrl.sv
design/video_fetch.sv
design/dma_copy.sv
design/ts_top.sv
tb/ts_top_checker.sv
tb/ts_top_tb.sv

// ==== Bender.yml ====
package:
  name: ts_mem_core

sources:
  - common/ts_pkg.sv
  - arbiter/dram_arbiter.sv
  - dram/dram_ctrl.sv
  - design/video_fetch.sv
  - design/dma_copy.sv
  - design/ts_top.sv
  - target: simulation
    files:
      - tb/ts_top_checker.sv
      - tb/ts_top_tb.sv
